//--- ball_tracker.f
hw/ball_pkg.sv
hw/pixel_if.sv
hw/stream_stage.sv
hw/pixel_decode.sv
hw/ball_execute.sv
hw/msg_result.sv
hw/ball_tracker.sv
bench/ball_tracker_tb.sv

//--- bench/ball_tracker_tb.sv
//////////////////////////////////////////////////////////////////////
// ball tracker testbench, video frames in, pixels and messages checked
//////////////////////////////////////////////////////////////////////

module ball_tracker_tb;
	import ball_pkg::*;

	localparam int IMAGE_W      = 16;
	localparam int IMAGE_H      = 4;
	localparam int HORIZON_ROW  = 2;
	localparam int RUN_LEN      = 3;
	localparam int MSG_INTERVAL = 2;
	localparam int MSG_DEPTH    = 32;

	// one pixel per colour that lands inside its classifier window
	localparam pixel_t BALL_PIX [NUM_BALLS] = '{24'hb43c00, 24'hfaf032, 24'h32c8a0, 24'hf0786e};

	logic       clk;
	logic       reset_n;
	logic       mode;
	pixel_t     sink_data;
	logic       sink_valid;
	logic       sink_ready;
	logic       sink_sop;
	logic       sink_eop;
	pixel_t     source_data;
	logic       source_valid;
	logic       source_ready = 1'b1;
	logic       source_sop;
	logic       source_eop;
	logic       s_chipselect;
	logic       s_read;
	logic       s_write;
	logic [2:0] s_address;
	word_t      s_writedata;
	word_t      s_readdata;

	logic [15:0] lfsr;
	logic        stall_en = 1'b0;
	string       test_name;
	int          err_mismatch;
	int          err_other;
	logic [25:0] exp_stream [$];
	logic [25:0] exp_word;
	word_t       exp_msg [$];
	int          exp_fill;
	logic [7:0]  stat_byte;

	// reference model state
	logic  m_video;
	int    m_col;
	int    m_row;
	ball_t m_prev;
	int    m_run;
	int    m_frames;
	int    m_min [NUM_BALLS];
	int    m_max [NUM_BALLS];

	ball_tracker #(
		.IMAGE_W(IMAGE_W), .HORIZON_ROW(HORIZON_ROW), .RUN_LEN(RUN_LEN),
		.MSG_INTERVAL(MSG_INTERVAL), .MSG_DEPTH(MSG_DEPTH)
	) uut (
		.clk(clk), .reset_n(reset_n), .mode(mode),
		.sink_data(sink_data), .sink_valid(sink_valid), .sink_ready(sink_ready),
		.sink_sop(sink_sop), .sink_eop(sink_eop),
		.source_data(source_data), .source_valid(source_valid),
		.source_ready(source_ready), .source_sop(source_sop), .source_eop(source_eop),
		.s_chipselect(s_chipselect), .s_read(s_read), .s_write(s_write),
		.s_address(s_address), .s_writedata(s_writedata), .s_readdata(s_readdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// random bits and reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic ball_t classify(input pixel_t p);
		int r;
		int g;
		int b;
		int v;
		int mn;
		int d;
		int s;
		int h;
		ball_t cls;
		r = p[23:16];
		g = p[15:8];
		b = p[7:0];
		v = (r > g) ? ((r > b) ? r : b) : ((g > b) ? g : b);
		mn = (r < g) ? ((r < b) ? r : b) : ((g < b) ? g : b);
		d = v - mn;
		s = (v == 0) ? 0 : d * 255 / v;
		h = 0;
		// half-degree hue, sector picked by the largest channel
		if (d != 0) begin
			if (v == b) h = (240 * d + 60 * (r - g)) / d / 2;
			else if (v == g) h = (120 * d + 60 * (b - r)) / d / 2;
			else if (b < g) h = (60 * (g - b)) / d / 2;
			else h = (360 * d + 60 * (g - b)) / d / 2;
		end
		cls = BALL_NONE;
		for (int i = 0; i < NUM_BALLS; i++) begin
			if (cls == BALL_NONE && h >= HUE_LO[i] && h <= HUE_HI[i] &&
				s >= SAT_LO[i] && s <= SAT_HI[i] && v >= VAL_LO[i] && v <= VAL_HI[i]) begin
				cls = ball_t'(i + 1);
			end
		end
		return cls;
	endfunction

	function automatic void model_sop(input pixel_t p);
		m_video = (p[3:0] == 4'h0);
		m_col = 0;
		m_row = 0;
		m_prev = BALL_NONE;
		m_run = 0;
		for (int i = 0; i < NUM_BALLS; i++) begin
			m_min[i] = IMAGE_W - 1;
			m_max[i] = 0;
		end
	endfunction

	function automatic void end_frame();
		logic found;
		m_frames++;
		if (m_frames % MSG_INTERVAL == 0) begin
			exp_msg.push_back(MSG_HEADER);
			for (int i = 0; i < NUM_BALLS; i++) begin
				found = (m_max[i] > 0) && (m_min[i] < IMAGE_W - 1);
				exp_msg.push_back({4'(i + 1), 3'b000, found, 1'b0, 11'(m_min[i]),
					1'b0, 11'(m_max[i])});
			end
			exp_fill += 1 + NUM_BALLS;
		end
	endfunction

	function automatic pixel_t model_pixel(input pixel_t p, input logic last);
		ball_t  cls;
		int     idx;
		logic   conf;
		chan_t  grey;
		pixel_t res;
		cls = classify(p);
		idx = int'(cls) - 1;
		m_run = (cls == m_prev) ? m_run + 1 : 1;
		m_prev = cls;
		conf = (cls != BALL_NONE) && (m_run >= RUN_LEN);
		if (conf && m_row >= HORIZON_ROW) begin
			if (m_col < m_min[idx]) m_min[idx] = m_col;
			if (m_col > m_max[idx]) m_max[idx] = m_col;
		end
		grey = chan_t'((p[15:8] >> 1) + (p[23:16] >> 2) + (p[7:0] >> 2));
		if (!mode || !m_video) res = p;
		else if (conf) res = HIGHLIGHT[idx];
		else res = {grey, grey, grey};
		m_col++;
		if (m_col == IMAGE_W) begin
			m_col = 0;
			m_row++;
		end
		if (last && m_video) end_frame();
		return res;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_pixel(input string what, input pixel_t exp, input pixel_t act);
		if (exp !== act) begin
			err_mismatch++;
			$display("Mismatch %s %s: expected %06h, actual %06h", test_name, what, exp, act);
		end
	endtask

	task automatic check_flags(input string what, input logic [1:0] exp, input logic [1:0] act);
		if (exp !== act) begin
			err_mismatch++;
			$display("Mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_word(input string what, input word_t exp, input word_t act);
		if (exp !== act) begin
			err_mismatch++;
			$display("Mismatch %s %s: expected %08h, actual %08h", test_name, what, exp, act);
		end
	endtask

	// outputs are sampled half a cycle before the edge that moves them
	always @(negedge clk) begin
		if (reset_n && source_valid && source_ready) begin
			if (exp_stream.size() == 0) begin
				err_other++;
				$display("Unexpected output word %06h in %s", source_data, test_name);
			end else begin
				exp_word = exp_stream.pop_front();
				check_pixel("pixel", exp_word[25:2], source_data);
				check_flags("sop/eop", exp_word[1:0], {source_sop, source_eop});
			end
		end
	end

	always @(posedge clk) begin
		source_ready <= stall_en ? (rand_bits(2) != 0) : 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic send_word(input pixel_t data, input logic sop, input logic eop);
		logic ready_seen;
		int   cycles;
		ready_seen = 1'b0;
		cycles = 0;
		sink_data <= data;
		sink_sop <= sop;
		sink_eop <= eop;
		sink_valid <= 1'b1;
		while (!ready_seen && cycles < 500) begin
			@(negedge clk);
			ready_seen = sink_ready;
			@(posedge clk);
			cycles++;
		end
		if (!ready_seen) begin
			err_other++;
			$display("Timeout: sink_ready stayed low in %s", test_name);
		end
	endtask

	task automatic send_frame(input logic video);
		pixel_t p;
		pixel_t sop_word;
		int     colour;
		int     start;
		int     len;
		logic   last;
		@(posedge clk);
		sop_word = pixel_t'(rand_bits(20)) << 4;
		if (!video) sop_word[3:0] = 4'(rand_bits(3) + 1);
		model_sop(sop_word);
		exp_stream.push_back({sop_word, 2'b10});
		send_word(sop_word, 1'b1, 1'b0);
		for (int row = 0; row < IMAGE_H; row++) begin
			// one ball run per row, colours rotate from frame to frame
			colour = (row + m_frames) % NUM_BALLS;
			len = 1 + rand_bits(3) % 5;
			start = rand_bits(4);
			if (start + len > IMAGE_W) start = IMAGE_W - len;
			for (int col = 0; col < IMAGE_W; col++) begin
				if (col >= start && col < start + len) p = BALL_PIX[colour];
				else p = pixel_t'(rand_bits(24));
				last = (row == IMAGE_H - 1) && (col == IMAGE_W - 1);
				exp_stream.push_back({model_pixel(p, last), 1'b0, last});
				send_word(p, 1'b0, last);
			end
		end
		sink_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_stream.size() != 0 && cycles < 5000) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_stream.size() != 0) begin
			err_other++;
			$display("Timeout: %0d output words never arrived in %s", exp_stream.size(), test_name);
		end
	endtask

	task automatic host_read(input logic [2:0] addr, output word_t data);
		@(posedge clk);
		s_chipselect <= 1'b1;
		s_read <= 1'b1;
		s_address <= addr;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_read <= 1'b0;
		@(negedge clk);
		data = s_readdata;
	endtask

	task automatic host_write(input logic [2:0] addr, input word_t data);
		@(posedge clk);
		s_chipselect <= 1'b1;
		s_write <= 1'b1;
		s_address <= addr;
		s_writedata <= data;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_write <= 1'b0;
	endtask

	// poll status until the fill level settles at n
	task automatic wait_fill(input int n);
		word_t rd;
		int    polls;
		polls = 0;
		host_read(ADDR_STATUS, rd);
		while (rd[15:8] != fill_t'(n) && polls < 100) begin
			host_read(ADDR_STATUS, rd);
			polls++;
		end
		if (rd[15:8] != fill_t'(n)) begin
			err_other++;
			$display("Timeout: FIFO fill level never reached %0d in %s", n, test_name);
		end
		check_word("status", {16'h0, fill_t'(n), stat_byte}, rd);
	endtask

	task automatic read_messages();
		word_t rd;
		wait_fill(exp_fill);
		while (exp_msg.size() != 0) begin
			host_read(ADDR_MSG, rd);
			check_word("message word", exp_msg.pop_front(), rd);
			exp_fill--;
		end
		wait_fill(exp_fill);
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		word_t rd;
		lfsr = 16'd65;
		err_mismatch = 0;
		err_other = 0;
		exp_fill = 0;
		stat_byte = 8'h00;
		m_frames = 0;
		reset_n = 1'b0;
		mode = 1'b0;
		sink_data = '0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_address = '0;
		s_writedata = '0;
		repeat (16) @(posedge clk);
		reset_n <= 1'b1;

		test_name = "pass_through";
		stall_en <= 1'b1;
		send_frame(1'b1);
		send_frame(1'b1);
		wait_drain();
		read_messages();

		// a non-video packet must not advance the frame pacing
		test_name = "non_video";
		@(posedge clk);
		mode <= 1'b1;
		send_frame(1'b0);
		send_frame(1'b1);
		wait_drain();
		repeat (8) @(posedge clk);
		wait_fill(0);

		test_name = "recolour";
		send_frame(1'b1);
		wait_drain();
		read_messages();

		test_name = "host_regs";
		send_frame(1'b1);
		send_frame(1'b1);
		wait_drain();
		wait_fill(exp_fill);
		repeat (2) begin
			host_read(ADDR_MSG, rd);
			check_word("message word", exp_msg.pop_front(), rd);
			exp_fill--;
		end
		wait_fill(exp_fill);
		host_write(ADDR_STATUS, word_t'(1) << FLUSH_BIT);
		stat_byte = 8'h10;
		exp_msg.delete();
		exp_fill = 0;
		wait_fill(0);
		host_read(ADDR_ID, rd);
		check_word("id", TRACKER_ID, rd);

		$display("Error count: %0d mismatches, %0d other failures", err_mismatch, err_other);
		if (err_mismatch == 0 && err_other == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- hw/ball_execute.sv
//////////////////////////////////////////////////////////////////////
// pixel coordinates, run filter, per-colour bounds and recolouring
//////////////////////////////////////////////////////////////////////

module ball_execute #(
	parameter int IMAGE_W     = 640,
	parameter int HORIZON_ROW = 280,
	parameter int RUN_LEN     = 6
) (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             mode,
	pixel_if.exe             px,
	bounds_if.exe            bnd,
	output ball_pkg::pixel_t out_pix
);
	import ball_pkg::*;

	localparam int CNT_W = $clog2(RUN_LEN) + 1;
	localparam int IDX_W = $clog2(NUM_BALLS);

	coord_t           col;
	coord_t           row;
	logic             packet_video;
	ball_t            run_cls;
	logic [CNT_W-1:0] run_cnt;
	logic             confirmed;
	logic             below_horizon;
	logic [IDX_W-1:0] cls_idx;
	chan_t            grey;
	coord_t           x_min   [NUM_BALLS];
	coord_t           x_max   [NUM_BALLS];
	coord_t           nxt_min [NUM_BALLS];
	coord_t           nxt_max [NUM_BALLS];

	// run_cnt counts earlier pixels of run_cls since sop
	assign confirmed = (px.cls != BALL_NONE) && (px.cls == run_cls) &&
		(run_cnt >= CNT_W'(RUN_LEN - 1));
	assign below_horizon = row >= coord_t'(HORIZON_ROW);
	assign cls_idx = IDX_W'(px.cls - 3'd1);

	always_comb begin
		for (int i = 0; i < NUM_BALLS; i++) begin
			nxt_min[i] = x_min[i];
			nxt_max[i] = x_max[i];
			if (confirmed && below_horizon && px.cls == ball_t'(i + 1)) begin
				if (col < x_min[i]) nxt_min[i] = col;
				if (col > x_max[i]) nxt_max[i] = col;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			col            <= '0;
			row            <= '0;
			packet_video   <= 1'b0;
			run_cls        <= BALL_NONE;
			run_cnt        <= '0;
			bnd.frame_done <= 1'b0;
			for (int i = 0; i < NUM_BALLS; i++) begin
				x_min[i] <= coord_t'(IMAGE_W - 1);
				x_max[i] <= '0;
			end
		end else begin
			bnd.frame_done <= 1'b0;
			if (px.accept && px.sop) begin
				col          <= '0;
				row          <= '0;
				packet_video <= (px.pix[3:0] == 4'h0);
				run_cls      <= BALL_NONE;
				run_cnt      <= '0;
				for (int i = 0; i < NUM_BALLS; i++) begin
					x_min[i] <= coord_t'(IMAGE_W - 1);
					x_max[i] <= '0;
				end
			end else if (px.accept) begin
				if (col == coord_t'(IMAGE_W - 1)) begin
					col <= '0;
					row <= row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
				if (px.cls == run_cls) begin
					if (run_cnt < CNT_W'(RUN_LEN - 1)) run_cnt <= run_cnt + 1'b1;
				end else begin
					run_cls <= px.cls;
					run_cnt <= CNT_W'(1);
				end
				x_min          <= nxt_min;
				x_max          <= nxt_max;
				bnd.frame_done <= px.eop && packet_video;
			end
		end
	end

	// bounds of a finished frame, eop pixel included
	always_ff @(posedge clk) begin
		if (px.accept && !px.sop && px.eop && packet_video) begin
			bnd.left  <= nxt_min;
			bnd.right <= nxt_max;
		end
	end

	always_comb begin
		grey = chan_t'(px.pix[15:9]) + chan_t'(px.pix[23:18]) + chan_t'(px.pix[7:2]);
		if (!mode || px.sop || !packet_video) begin
			out_pix = px.pix;
		end else if (confirmed) begin
			out_pix = HIGHLIGHT[cls_idx];
		end else begin
			out_pix = {grey, grey, grey};
		end
	end

	a_single_done: assert property (@(posedge clk) disable iff (!reset_n)
		bnd.frame_done |=> !bnd.frame_done)
		else $error("ball_execute: frame_done held for two cycles");

endmodule

//--- hw/ball_pkg.sv
//////////////////////////////////////////////////////////////////////
// ball tracker shared types, colour thresholds, message layout
// and host register map
//////////////////////////////////////////////////////////////////////

package ball_pkg;

	typedef logic [23:0] pixel_t;
	typedef logic [7:0]  chan_t;
	typedef logic [10:0] coord_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0]  fill_t;

	// ball classes, red is 1 so the class doubles as the message colour number
	typedef enum logic [2:0] {
		BALL_NONE,
		BALL_RED,
		BALL_YELLOW,
		BALL_TEAL,
		BALL_PINK
	} ball_t;

	localparam int NUM_BALLS = 4;

	//////////////////////////////////////////////////////////////////////
	// classifier limits, index 0 is red and index 3 is pink
	//////////////////////////////////////////////////////////////////////

	// hue on the half-degree scale
	localparam chan_t HUE_LO [NUM_BALLS] = '{8'd7,   8'd24,  8'd60,  8'd1};
	localparam chan_t HUE_HI [NUM_BALLS] = '{8'd12,  8'd31,  8'd85,  8'd8};

	localparam chan_t SAT_LO [NUM_BALLS] = '{8'd220, 8'd179, 8'd101, 8'd100};
	localparam chan_t SAT_HI [NUM_BALLS] = '{8'd255, 8'd214, 8'd199, 8'd203};

	// open-ended upper limits sit at full scale
	localparam chan_t VAL_LO [NUM_BALLS] = '{8'd75,  8'd244, 8'd111, 8'd189};
	localparam chan_t VAL_HI [NUM_BALLS] = '{8'd189, 8'd255, 8'd244, 8'd255};

	// recolour table for confirmed pixels
	localparam pixel_t HIGHLIGHT [NUM_BALLS] = '{
		24'hff1000,
		24'hffff00,
		24'h008080,
		24'hdf55e2
	};

	//////////////////////////////////////////////////////////////////////
	// messages and host port
	//////////////////////////////////////////////////////////////////////

	// first word of every bounds message
	localparam word_t MSG_HEADER = "RBB";
	localparam word_t TRACKER_ID = 32'h1234eee2;

	localparam logic [2:0] ADDR_STATUS = 3'd0;
	localparam logic [2:0] ADDR_MSG    = 3'd1;
	localparam logic [2:0] ADDR_ID     = 3'd2;

	// status bit that empties the message FIFO
	localparam int FLUSH_BIT = 4;

endpackage

//--- hw/ball_tracker.sv
//////////////////////////////////////////////////////////////////////
// streaming ball tracker top, video in and out with a host port
//////////////////////////////////////////////////////////////////////

module ball_tracker #(
	parameter int IMAGE_W      = 640,
	parameter int HORIZON_ROW  = 280,
	parameter int RUN_LEN      = 6,
	parameter int MSG_INTERVAL = 6,
	parameter int MSG_DEPTH    = 128
) (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             mode,
	// video in
	input  ball_pkg::pixel_t sink_data,
	input  logic             sink_valid,
	output logic             sink_ready,
	input  logic             sink_sop,
	input  logic             sink_eop,
	// video out
	output ball_pkg::pixel_t source_data,
	output logic             source_valid,
	input  logic             source_ready,
	output logic             source_sop,
	output logic             source_eop,
	// host port
	input  logic             s_chipselect,
	input  logic             s_read,
	input  logic             s_write,
	input  logic [2:0]       s_address,
	input  ball_pkg::word_t  s_writedata,
	output ball_pkg::word_t  s_readdata
);
	import ball_pkg::*;

	// pixel plus sop and eop
	localparam int DATA_W = $bits(pixel_t) + 2;

	logic [DATA_W-1:0] in_word;
	logic [DATA_W-1:0] out_word;
	logic              in_valid;
	logic              stage_ready;
	pixel_t            exe_pix;

	pixel_if  pix_bus ();
	bounds_if bnd_bus ();

	stream_stage #(.DATA_W(DATA_W)) in_stage (
		.clk(clk), .reset_n(reset_n),
		.in_valid(sink_valid), .in_ready(sink_ready),
		.in_data({sink_data, sink_sop, sink_eop}),
		.out_valid(in_valid), .out_ready(stage_ready), .out_data(in_word)
	);

	pixel_decode u_decode (
		.in_valid(in_valid), .in_data(in_word), .out_ready(stage_ready), .px(pix_bus.dec)
	);

	ball_execute #(.IMAGE_W(IMAGE_W), .HORIZON_ROW(HORIZON_ROW), .RUN_LEN(RUN_LEN)) u_execute (
		.clk(clk), .reset_n(reset_n), .mode(mode),
		.px(pix_bus.exe), .bnd(bnd_bus.exe), .out_pix(exe_pix)
	);

	stream_stage #(.DATA_W(DATA_W)) out_stage (
		.clk(clk), .reset_n(reset_n),
		.in_valid(in_valid), .in_ready(stage_ready),
		.in_data({exe_pix, pix_bus.sop, pix_bus.eop}),
		.out_valid(source_valid), .out_ready(source_ready), .out_data(out_word)
	);

	assign {source_data, source_sop, source_eop} = out_word;

	msg_result #(.IMAGE_W(IMAGE_W), .MSG_INTERVAL(MSG_INTERVAL), .MSG_DEPTH(MSG_DEPTH)) u_result (
		.clk(clk), .reset_n(reset_n), .bnd(bnd_bus.res),
		.s_chipselect(s_chipselect), .s_read(s_read), .s_write(s_write),
		.s_address(s_address), .s_writedata(s_writedata), .s_readdata(s_readdata)
	);

endmodule

//--- hw/msg_result.sv
//////////////////////////////////////////////////////////////////////
// frame pacing, bounds message writer, message FIFO and host port
//////////////////////////////////////////////////////////////////////

module msg_result #(
	parameter int IMAGE_W      = 640,
	parameter int MSG_INTERVAL = 6,
	parameter int MSG_DEPTH    = 128
) (
	input  logic            clk,
	input  logic            reset_n,
	bounds_if.res           bnd,
	input  logic            s_chipselect,
	input  logic            s_read,
	input  logic            s_write,
	input  logic [2:0]      s_address,
	input  ball_pkg::word_t s_writedata,
	output ball_pkg::word_t s_readdata
);
	import ball_pkg::*;

	localparam int PTR_W = $clog2(MSG_DEPTH);
	localparam int IDX_W = $clog2(NUM_BALLS);
	localparam int FC_W  = $clog2(MSG_INTERVAL) + 1;

	typedef enum logic [1:0] {ST_IDLE, ST_HEADER, ST_COLOURS} wr_state_t;

	wr_state_t        state;
	logic [IDX_W-1:0] col_idx;
	logic [FC_W-1:0]  frame_cnt;
	logic             room;
	logic             found;
	word_t            mem [MSG_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	fill_t            count;
	logic             fifo_wr;
	logic             fifo_rd;
	word_t            fifo_din;
	logic             flush;
	logic             read_d;
	logic [7:0]       reg_status;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(MSG_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// a whole message must fit before the writer starts
	assign room = (fill_t'(MSG_DEPTH) - count) >= fill_t'(1 + NUM_BALLS);

	//////////////////////////////////////////////////////////////////////
	// pacing and message writer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_cnt <= FC_W'(MSG_INTERVAL - 1);
			state     <= ST_IDLE;
			col_idx   <= '0;
		end else begin
			// counter parks at zero until there is room
			if (bnd.frame_done) begin
				if (frame_cnt != '0) begin
					frame_cnt <= frame_cnt - 1'b1;
				end else if (room && state == ST_IDLE) begin
					frame_cnt <= FC_W'(MSG_INTERVAL - 1);
					state     <= ST_HEADER;
				end
			end
			case (state)
				ST_HEADER: begin
					state   <= ST_COLOURS;
					col_idx <= '0;
				end
				ST_COLOURS: begin
					if (col_idx == IDX_W'(NUM_BALLS - 1)) state <= ST_IDLE;
					else col_idx <= col_idx + 1'b1;
				end
				default: ;
			endcase
		end
	end

	// colour word holds number, found flag, left and right
	always_comb begin
		found    = (bnd.right[col_idx] != '0) &&
			(bnd.left[col_idx] < coord_t'(IMAGE_W - 1));
		fifo_wr  = 1'b0;
		fifo_din = '0;
		case (state)
			ST_HEADER: begin
				fifo_wr  = 1'b1;
				fifo_din = MSG_HEADER;
			end
			ST_COLOURS: begin
				fifo_wr  = 1'b1;
				fifo_din = {4'(col_idx) + 4'd1, 3'b000, found,
					1'b0, bnd.left[col_idx], 1'b0, bnd.right[col_idx]};
			end
			default: ;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// message FIFO
	//////////////////////////////////////////////////////////////////////

	assign flush = s_chipselect && s_write && (s_address == ADDR_STATUS) &&
		s_writedata[FLUSH_BIT];
	// one pop per read burst
	assign fifo_rd = s_chipselect && s_read && !read_d && (count != '0) &&
		(s_address == ADDR_MSG);

	always_ff @(posedge clk) begin
		if (!reset_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (fifo_wr) wr_ptr <= ptr_next(wr_ptr);
			if (fifo_rd) rd_ptr <= ptr_next(rd_ptr);
			count <= count + fill_t'(fifo_wr) - fill_t'(fifo_rd);
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_wr) mem[wr_ptr] <= fifo_din;
	end

	//////////////////////////////////////////////////////////////////////
	// host registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			reg_status <= '0;
		end else if (s_chipselect && s_write && s_address == ADDR_STATUS) begin
			reg_status <= s_writedata[7:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s_readdata <= '0;
			read_d     <= 1'b0;
		end else begin
			read_d <= s_read;
			if (s_chipselect && s_read) begin
				case (s_address)
					ADDR_STATUS: s_readdata <= {16'h0, count, reg_status};
					ADDR_MSG:    s_readdata <= mem[rd_ptr];
					ADDR_ID:     s_readdata <= TRACKER_ID;
					default:     s_readdata <= '0;
				endcase
			end
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
		fifo_wr |-> count != fill_t'(MSG_DEPTH))
		else $error("msg_result: write into full FIFO");

	// equal pointers mean empty unless the count says full
	a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
		fifo_rd |-> (rd_ptr != wr_ptr) || (count == fill_t'(MSG_DEPTH)))
		else $error("msg_result: pop from empty FIFO");

endmodule

//--- hw/pixel_decode.sv
//////////////////////////////////////////////////////////////////////
// RGB to HSV conversion and ball colour classification
//////////////////////////////////////////////////////////////////////

module pixel_decode (
	input  logic                                 in_valid,
	input  logic [$bits(ball_pkg::pixel_t)+1:0] in_data,
	input  logic                                 out_ready,
	pixel_if.dec                                 px
);
	import ball_pkg::*;

	chan_t red;
	chan_t green;
	chan_t blue;
	chan_t value;
	chan_t min_c;
	chan_t sat;
	chan_t hue;
	logic  sop;
	logic  eop;

	assign {red, green, blue, sop, eop} = in_data;

	assign px.pix    = {red, green, blue};
	assign px.sop    = sop;
	assign px.eop    = eop;
	assign px.accept = in_valid && out_ready;

	// value is the largest channel, min the smallest
	assign value = (red > green) ? ((red > blue) ? red : blue) : ((green > blue) ? green : blue);
	assign min_c = (red < green) ? ((red < blue) ? red : blue) : ((green < blue) ? green : blue);

	assign sat = (value == '0) ? '0 : chan_t'((16'(value - min_c) * 16'd255) / 16'(value));

	//////////////////////////////////////////////////////////////////////
	// hue, halved so 360 degrees fits in a byte
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		int delta;
		int num;

		delta = int'(value) - int'(min_c);
		num   = 0;
		hue   = '0;
		if (delta != 0) begin
			if (value != red) begin
				if (value != green) begin
					// blue is largest
					num = 240 * delta + 60 * (int'(red) - int'(green));
				end else begin
					num = 120 * delta + 60 * (int'(blue) - int'(red));
				end
			end else if (blue < green) begin
				num = 60 * (int'(green) - int'(blue));
			end else begin
				// red largest, wraps towards 360
				num = 360 * delta + 60 * (int'(green) - int'(blue));
			end
			hue = chan_t'((num / delta) >> 1);
		end
	end

	// lowest class wins when two windows overlap
	always_comb begin
		px.cls = BALL_NONE;
		for (int i = NUM_BALLS - 1; i >= 0; i--) begin
			if (hue >= HUE_LO[i] && hue <= HUE_HI[i] &&
				sat >= SAT_LO[i] && sat <= SAT_HI[i] &&
				value >= VAL_LO[i] && value <= VAL_HI[i]) begin
				px.cls = ball_t'(i + 1);
			end
		end
	end

endmodule

//--- hw/pixel_if.sv
//////////////////////////////////////////////////////////////////////
// classified pixel from decode to execute, and frame bounds
// from execute to the result stage
//////////////////////////////////////////////////////////////////////

interface pixel_if;
	import ball_pkg::*;

	pixel_t pix;
	logic   sop;
	logic   eop;
	ball_t  cls;
	// word moves from the input slice to the output slice this cycle
	logic   accept;

	modport dec (output pix, output sop, output eop, output cls, output accept);
	modport exe (input pix, input sop, input eop, input cls, input accept);
endinterface

interface bounds_if;
	import ball_pkg::*;

	logic   frame_done;
	coord_t left  [NUM_BALLS];
	coord_t right [NUM_BALLS];

	modport exe (output frame_done, output left, output right);
	modport res (input frame_done, input left, input right);
endinterface

//--- hw/stream_stage.sv
//////////////////////////////////////////////////////////////////////
// one-entry valid/ready register slice
//////////////////////////////////////////////////////////////////////

module stream_stage #(
	parameter int DATA_W = 26
) (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              in_valid,
	output logic              in_ready,
	input  logic [DATA_W-1:0] in_data,
	output logic              out_valid,
	input  logic              out_ready,
	output logic [DATA_W-1:0] out_data
);

	// take a new word when empty or when the held one leaves
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_ready && in_valid) begin
			out_data <= in_data;
		end
	end

	a_hold_stable: assert property (@(posedge clk) disable iff (!reset_n)
		out_valid && !out_ready |=> $stable(out_data))
		else $error("stream_stage: data changed while stalled");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the ball tracker testbench with Verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module ball_tracker_tb -f ball_tracker.f \
	--Mdir obj_dir -o ball_tracker_sim

./obj_dir/ball_tracker_sim | tee sim.log

if grep -q "Checks failed" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation finished without failures"
